/* src/dcache_pkg.sv */
package dcache_pkg;

    // cpu side data and address
    typedef logic [31:0] word_t;
    typedef logic [31:0] addr_t;

    // one enable per byte lane, all zero for a load
    typedef logic [3:0] strb_t;

    // controller states
    typedef enum logic [1:0] {
        IDLE,       // wait for req, arrays read with the request index
        LOOKUP,     // tag compare on the array outputs
        WRITEBACK,  // dirty victim goes out as a write burst
        REFILL      // new line comes in as a read burst
    } dcache_state_e;

endpackage

/* src/dcache_axi_pkg.sv */
package dcache_axi_pkg;

    typedef logic [3:0] axi_len_t;   // beats in burst minus one
    typedef logic [2:0] axi_size_t;  // log2 of bytes per beat

    // every beat carries one full 32-bit word
    localparam axi_size_t AXI_SIZE_WORD = 3'b010;

endpackage

/* src/dcache_sram.sv */
`timescale 1ns/1ps

module dcache_sram #(
    parameter int DEPTH_WIDTH = 7,
    parameter type payload_t = logic [31:0]
) (
    input  logic                   clk,
    input  logic                   wr_en,
    input  logic [DEPTH_WIDTH-1:0] wr_addr,
    input  payload_t               wr_data,
    input  logic [DEPTH_WIDTH-1:0] rd_addr,
    output payload_t               rd_data
);

    localparam int DEPTH = 1 << DEPTH_WIDTH;

    payload_t mem [DEPTH];

    // read returns old contents on a same-address write
    always_ff @(posedge clk) begin
        if (wr_en) begin
            mem[wr_addr] <= wr_data;
        end
        rd_data <= mem[rd_addr];  // one cycle read latency
    end

endmodule

/* src/dcache_way.sv */
`timescale 1ns/1ps

module dcache_way
    import dcache_pkg::*;
#(
    parameter int INDEX_WIDTH = 7,
    parameter int LINE_WORDS  = 8,
    localparam int SEL_WIDTH  = $clog2(LINE_WORDS),
    localparam int TAG_WIDTH  = 32 - INDEX_WIDTH - SEL_WIDTH - 2
) (
    input  logic                   clk,
    input  logic                   rst,
    input  logic [INDEX_WIDTH-1:0] lookup_index,
    input  logic [TAG_WIDTH-1:0]   lookup_tag,
    input  logic [SEL_WIDTH-1:0]   word_sel,
    input  logic                   tag_wr,
    input  logic                   set_valid,
    input  logic                   wr_en,
    input  word_t                  wr_word,
    input  logic                   dirty_wr,
    input  logic                   dirty_val,
    output logic                   hit,
    output logic                   dirty,
    output logic [TAG_WIDTH-1:0]   tag_out,
    output word_t                  rd_word
);

    localparam int SETS = 1 << INDEX_WIDTH;

    typedef logic [TAG_WIDTH-1:0] tag_t;

    logic [SETS-1:0]                  valid_bits;
    logic [SETS-1:0]                  dirty_bits;
    logic [INDEX_WIDTH+SEL_WIDTH-1:0] data_addr;

    assign data_addr = {lookup_index, word_sel};  // set, then word in line

    dcache_sram #(
        .DEPTH_WIDTH (INDEX_WIDTH),
        .payload_t   (tag_t)
    ) i_tag_ram (
        .clk     (clk),
        .wr_en   (tag_wr),
        .wr_addr (lookup_index),
        .wr_data (lookup_tag),
        .rd_addr (lookup_index),
        .rd_data (tag_out)
    );

    dcache_sram #(
        .DEPTH_WIDTH (INDEX_WIDTH + SEL_WIDTH),
        .payload_t   (word_t)
    ) i_data_ram (
        .clk     (clk),
        .wr_en   (wr_en),
        .wr_addr (data_addr),
        .wr_data (wr_word),
        .rd_addr (data_addr),
        .rd_data (rd_word)
    );

    always_ff @(posedge clk) begin
        if (rst) begin
            valid_bits <= '0;
            dirty_bits <= '0;
        end else begin
            if (set_valid) begin
                valid_bits[lookup_index] <= 1'b1;
            end
            if (dirty_wr) begin
                dirty_bits[lookup_index] <= dirty_val;
            end
        end
    end

    // index is held, so the flop bits line up with the ram outputs
    assign hit   = valid_bits[lookup_index] & (tag_out == lookup_tag);
    assign dirty = valid_bits[lookup_index] & dirty_bits[lookup_index];

endmodule

/* src/dcache_plru.sv */
`timescale 1ns/1ps

module dcache_plru #(
    parameter int INDEX_WIDTH = 7
) (
    input  logic                   clk,
    input  logic                   rst,
    input  logic [INDEX_WIDTH-1:0] index,
    input  logic                   touch_en,
    input  logic [1:0]             touch_way,
    output logic [1:0]             victim
);

    localparam int SETS = 1 << INDEX_WIDTH;

    // bit0 picks the half, bit1 covers ways 0/1, bit2 covers ways 2/3
    logic [2:0] lru_bits [SETS];
    logic [2:0] cur_bits;

    assign cur_bits = lru_bits[index];
    assign victim   = {cur_bits[0], cur_bits[0] ? cur_bits[2] : cur_bits[1]};

    always_ff @(posedge clk) begin
        if (rst) begin
            for (int s = 0; s < SETS; s++) begin
                lru_bits[s] <= 3'b000;
            end
        end else if (touch_en) begin
            lru_bits[index][0] <= ~touch_way[1];  // point at the other half
            if (touch_way[1]) begin
                lru_bits[index][2] <= ~touch_way[0];
            end else begin
                lru_bits[index][1] <= ~touch_way[0];
            end
        end
    end

endmodule

/* src/dcache_ctrl.sv */
`timescale 1ns/1ps

module dcache_ctrl
    import dcache_pkg::*;
    import dcache_axi_pkg::*;
#(
    parameter int INDEX_WIDTH   = 7,
    parameter int LINE_WORDS    = 8,
    localparam int SEL_WIDTH    = $clog2(LINE_WORDS),
    localparam int OFFSET_WIDTH = SEL_WIDTH + 2,
    localparam int TAG_WIDTH    = 32 - INDEX_WIDTH - OFFSET_WIDTH
) (
    input  logic                   clk,
    input  logic                   rst,
    // load/store port
    input  logic                   req,
    input  addr_t                  addr,
    input  strb_t                  wen,
    input  word_t                  wdata,
    output logic                   stall,
    output word_t                  rdata,
    // ways
    input  logic [3:0]             way_hit,
    input  logic [3:0]             way_dirty,
    input  word_t                  way_word [4],
    input  logic [TAG_WIDTH-1:0]   way_tag [4],
    output logic [INDEX_WIDTH-1:0] lookup_index,
    output logic [TAG_WIDTH-1:0]   lookup_tag,
    output logic [SEL_WIDTH-1:0]   word_sel,
    output logic [3:0]             wr_en,
    output word_t                  wr_word,
    output logic [3:0]             set_valid,
    output logic [3:0]             dirty_wr,
    output logic                   dirty_val,
    output logic [3:0]             tag_wr,
    // replacement
    input  logic [1:0]             victim,
    output logic                   touch_en,
    output logic [1:0]             touch_way,
    // memory bus
    output addr_t                  araddr,
    output axi_len_t               arlen,
    output axi_size_t              arsize,
    output logic                   arvalid,
    input  logic                   arready,
    input  word_t                  rdata_bus,
    input  logic                   rlast,
    input  logic                   rvalid,
    output logic                   rready,
    output addr_t                  awaddr,
    output axi_len_t               awlen,
    output axi_size_t              awsize,
    output logic                   awvalid,
    input  logic                   awready,
    output word_t                  wdata_bus,
    output strb_t                  wstrb,
    output logic                   wlast,
    output logic                   wvalid,
    input  logic                   wready,
    input  logic                   bvalid,
    output logic                   bready
);

    dcache_state_e state;

    logic [1:0]           vway;     // way being replaced
    logic [1:0]           hit_way;
    logic                 ar_done;
    logic                 aw_done;
    logic                 w_done;
    logic [SEL_WIDTH-1:0] wcnt;
    logic [SEL_WIDTH-1:0] rcnt;
    logic [SEL_WIDTH-1:0] req_sel;
    logic                 any_hit;
    logic                 store;
    logic                 complete;
    logic                 ar_hs;
    logic                 r_hs;
    logic                 aw_hs;
    logic                 w_hs;
    logic                 b_hs;
    word_t                bmask;
    word_t                hit_word;

    assign lookup_index = addr[OFFSET_WIDTH +: INDEX_WIDTH];
    assign lookup_tag   = addr[31 -: TAG_WIDTH];
    assign req_sel      = addr[2 +: SEL_WIDTH];
    assign store        = |wen;
    assign bmask        = {{8{wen[3]}}, {8{wen[2]}}, {8{wen[1]}}, {8{wen[0]}}};

    // one-hot hit vector to way number
    always_comb begin
        hit_way = 2'd0;
        for (int i = 0; i < 4; i++) begin
            if (way_hit[i]) begin
                hit_way = 2'(i);
            end
        end
    end

    assign any_hit  = |way_hit;
    assign complete = (state == LOOKUP) & req & any_hit;
    assign stall    = req & ~complete;
    assign hit_word = way_word[hit_way];
    assign rdata    = hit_word;

    assign ar_hs = arvalid & arready;
    assign r_hs  = rvalid & rready;
    assign aw_hs = awvalid & awready;
    assign w_hs  = wvalid & wready;
    assign b_hs  = bvalid & bready;

    // refill reads the requested line, write-back uses the victim tag
    assign araddr  = {lookup_tag, lookup_index, {OFFSET_WIDTH{1'b0}}};
    assign arlen   = axi_len_t'(LINE_WORDS - 1);
    assign arsize  = AXI_SIZE_WORD;
    assign arvalid = (state == REFILL) & ~ar_done;
    assign rready  = (state == REFILL) & ar_done;

    assign awaddr    = {way_tag[vway], lookup_index, {OFFSET_WIDTH{1'b0}}};
    assign awlen     = axi_len_t'(LINE_WORDS - 1);
    assign awsize    = AXI_SIZE_WORD;
    assign awvalid   = (state == WRITEBACK) & ~aw_done;
    assign wvalid    = (state == WRITEBACK) & aw_done & ~w_done;
    assign wdata_bus = way_word[vway];
    assign wstrb     = '1;  // whole line goes out
    assign wlast     = wcnt == SEL_WIDTH'(LINE_WORDS - 1);
    assign bready    = (state == WRITEBACK) & aw_done;

    // data ram address, chosen one cycle ahead of the word that is needed
    always_comb begin
        case (state)
            WRITEBACK: word_sel = w_hs ? wcnt + 1'b1 : wcnt;
            REFILL:    word_sel = rcnt;
            LOOKUP:    word_sel = (req & ~any_hit) ? '0 : req_sel;  // word 0 for write-back
            default:   word_sel = req_sel;
        endcase
    end

    always_comb begin
        wr_en     = '0;
        tag_wr    = '0;
        set_valid = '0;
        dirty_wr  = '0;
        dirty_val = 1'b0;
        wr_word   = rdata_bus;
        touch_en  = 1'b0;
        touch_way = hit_way;
        if (complete) begin
            touch_en = 1'b1;
            if (store) begin
                wr_en[hit_way]    = 1'b1;
                wr_word           = (hit_word & ~bmask) | (wdata & bmask);
                dirty_wr[hit_way] = 1'b1;
                dirty_val         = 1'b1;
            end
        end
        if (state == REFILL) begin
            touch_way    = vway;
            tag_wr[vway] = ar_hs;  // tag goes in once the burst is accepted
            wr_en[vway]  = r_hs;
            if (store && rcnt == req_sel) begin
                wr_word = (rdata_bus & ~bmask) | (wdata & bmask);
            end
            if (r_hs && rlast) begin
                set_valid[vway] = 1'b1;
                dirty_wr[vway]  = 1'b1;
                dirty_val       = store;  // load refill leaves line clean
                touch_en        = 1'b1;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            state   <= IDLE;
            vway    <= 2'd0;
            ar_done <= 1'b0;
            aw_done <= 1'b0;
            w_done  <= 1'b0;
            wcnt    <= '0;
            rcnt    <= '0;
        end else begin
            case (state)
                IDLE: begin
                    if (req) begin
                        state <= LOOKUP;
                    end
                end
                LOOKUP: begin
                    if (!req || any_hit) begin
                        state <= IDLE;
                    end else begin
                        vway  <= victim;
                        state <= way_dirty[victim] ? WRITEBACK : REFILL;
                    end
                end
                WRITEBACK: begin
                    if (aw_hs) begin
                        aw_done <= 1'b1;
                    end
                    if (w_hs) begin
                        wcnt <= wcnt + 1'b1;  // wraps to 0 after the last beat
                        if (wlast) begin
                            w_done <= 1'b1;
                        end
                    end
                    if (b_hs) begin
                        aw_done <= 1'b0;
                        w_done  <= 1'b0;
                        state   <= REFILL;
                    end
                end
                REFILL: begin
                    if (ar_hs) begin
                        ar_done <= 1'b1;
                    end
                    if (r_hs) begin
                        rcnt <= rcnt + 1'b1;
                        if (rlast) begin
                            ar_done <= 1'b0;
                            rcnt    <= '0;
                            state   <= IDLE;  // arrays reread, then LOOKUP hits
                        end
                    end
                end
            endcase
        end
    end

endmodule

/* src/dcache_top.sv */
`timescale 1ns/1ps

module dcache_top
    import dcache_pkg::*;
    import dcache_axi_pkg::*;
#(
    parameter int INDEX_WIDTH = 7,
    parameter int LINE_WORDS  = 8
) (
    input  logic      clk,
    input  logic      rst,
    // load/store port
    input  logic      req,
    input  addr_t     addr,
    input  strb_t     wen,
    input  word_t     wdata,
    output word_t     rdata,
    output logic      stall,
    // read channels
    output addr_t     araddr,
    output axi_len_t  arlen,
    output axi_size_t arsize,
    output logic      arvalid,
    input  logic      arready,
    input  word_t     rdata_bus,
    input  logic      rlast,
    input  logic      rvalid,
    output logic      rready,
    // write channels
    output addr_t     awaddr,
    output axi_len_t  awlen,
    output axi_size_t awsize,
    output logic      awvalid,
    input  logic      awready,
    output word_t     wdata_bus,
    output strb_t     wstrb,
    output logic      wlast,
    output logic      wvalid,
    input  logic      wready,
    input  logic      bvalid,
    output logic      bready
);

    localparam int SEL_WIDTH = $clog2(LINE_WORDS);
    localparam int TAG_WIDTH = 32 - INDEX_WIDTH - SEL_WIDTH - 2;

    logic [INDEX_WIDTH-1:0] lookup_index;
    logic [TAG_WIDTH-1:0]   lookup_tag;
    logic [SEL_WIDTH-1:0]   word_sel;
    logic [3:0]             wr_en;
    word_t                  wr_word;
    logic [3:0]             set_valid;
    logic [3:0]             dirty_wr;
    logic                   dirty_val;
    logic [3:0]             tag_wr;
    logic [3:0]             way_hit;
    logic [3:0]             way_dirty;
    word_t                  way_word [4];
    logic [TAG_WIDTH-1:0]   way_tag [4];
    logic [1:0]             victim;
    logic                   touch_en;
    logic [1:0]             touch_way;

    dcache_ctrl #(
        .INDEX_WIDTH (INDEX_WIDTH),
        .LINE_WORDS  (LINE_WORDS)
    ) i_ctrl (
        .clk          (clk),
        .rst          (rst),
        .req          (req),
        .addr         (addr),
        .wen          (wen),
        .wdata        (wdata),
        .stall        (stall),
        .rdata        (rdata),
        .way_hit      (way_hit),
        .way_dirty    (way_dirty),
        .way_word     (way_word),
        .way_tag      (way_tag),
        .lookup_index (lookup_index),
        .lookup_tag   (lookup_tag),
        .word_sel     (word_sel),
        .wr_en        (wr_en),
        .wr_word      (wr_word),
        .set_valid    (set_valid),
        .dirty_wr     (dirty_wr),
        .dirty_val    (dirty_val),
        .tag_wr       (tag_wr),
        .victim       (victim),
        .touch_en     (touch_en),
        .touch_way    (touch_way),
        .araddr       (araddr),
        .arlen        (arlen),
        .arsize       (arsize),
        .arvalid      (arvalid),
        .arready      (arready),
        .rdata_bus    (rdata_bus),
        .rlast        (rlast),
        .rvalid       (rvalid),
        .rready       (rready),
        .awaddr       (awaddr),
        .awlen        (awlen),
        .awsize       (awsize),
        .awvalid      (awvalid),
        .awready      (awready),
        .wdata_bus    (wdata_bus),
        .wstrb        (wstrb),
        .wlast        (wlast),
        .wvalid       (wvalid),
        .wready       (wready),
        .bvalid       (bvalid),
        .bready       (bready)
    );

    dcache_plru #(
        .INDEX_WIDTH (INDEX_WIDTH)
    ) i_plru (
        .clk       (clk),
        .rst       (rst),
        .index     (lookup_index),
        .touch_en  (touch_en),
        .touch_way (touch_way),
        .victim    (victim)
    );

    // four ways share index, tag and write data, each has its own enables
    for (genvar g = 0; g < 4; g++) begin : g_way
        dcache_way #(
            .INDEX_WIDTH (INDEX_WIDTH),
            .LINE_WORDS  (LINE_WORDS)
        ) i_way (
            .clk          (clk),
            .rst          (rst),
            .lookup_index (lookup_index),
            .lookup_tag   (lookup_tag),
            .word_sel     (word_sel),
            .tag_wr       (tag_wr[g]),
            .set_valid    (set_valid[g]),
            .wr_en        (wr_en[g]),
            .wr_word      (wr_word),
            .dirty_wr     (dirty_wr[g]),
            .dirty_val    (dirty_val),
            .hit          (way_hit[g]),
            .dirty        (way_dirty[g]),
            .tag_out      (way_tag[g]),
            .rd_word      (way_word[g])
        );
    end

endmodule

/* sim/axi_mem_model.sv */
`timescale 1ns/1ps

module axi_mem_model
    import dcache_pkg::*;
    import dcache_axi_pkg::*;
#(
    parameter int SEED = 0
) (
    input  logic     clk,
    input  logic     rst,
    // read channels
    input  addr_t    araddr,
    input  axi_len_t arlen,
    input  logic     arvalid,
    output logic     arready,
    output word_t    rdata_bus,
    output logic     rlast,
    output logic     rvalid,
    input  logic     rready,
    // write channels
    input  addr_t    awaddr,
    input  logic     awvalid,
    output logic     awready,
    input  word_t    wdata_bus,
    input  strb_t    wstrb,
    input  logic     wlast,
    input  logic     wvalid,
    output logic     wready,
    output logic     bvalid,
    input  logic     bready
);

    word_t    mem [addr_t];  // only stored words, keyed by word address
    int       seed = SEED;
    int       rnd;
    word_t    merged;
    logic     ar_rdy = 1'b0;
    logic     aw_rdy = 1'b0;
    logic     w_rdy  = 1'b0;
    logic     r_busy = 1'b0;
    logic     r_lst  = 1'b0;
    addr_t    r_addr = '0;
    axi_len_t r_left = '0;   // beats still to send after this one
    word_t    r_dat  = '0;
    logic     w_busy = 1'b0;
    logic     b_vld  = 1'b0;
    addr_t    w_addr = '0;

    assign arready   = ar_rdy;
    assign awready   = aw_rdy;
    assign wready    = w_rdy;
    assign rvalid    = r_busy;  // beats follow back to back
    assign rlast     = r_lst;
    assign rdata_bus = r_dat;
    assign bvalid    = b_vld;

    // words never stored read as the init pattern
    function automatic word_t read_word(addr_t a);
        addr_t wa;
        wa = {a[31:2], 2'b00};
        if (mem.exists(wa)) begin
            return mem[wa];
        end
        return wa ^ 32'hc0de0000;
    endfunction

    always @(posedge clk) begin
        rnd = $random(seed);
        if (rst) begin
            ar_rdy <= 1'b0;
            aw_rdy <= 1'b0;
            w_rdy  <= 1'b0;
            r_busy <= 1'b0;
            r_lst  <= 1'b0;
            w_busy <= 1'b0;
            b_vld  <= 1'b0;
        end else begin
            ar_rdy <= rnd[0];  // random back-pressure on each channel
            aw_rdy <= rnd[1];
            w_rdy  <= rnd[2];

            // one read burst at a time
            if (r_busy) begin
                if (rready) begin
                    r_busy <= ~r_lst;
                    r_lst  <= r_left == 4'd1;
                    r_left <= r_left - 1'b1;
                    r_addr <= r_addr + 4;
                    r_dat  <= read_word(r_addr + 4);
                end
            end else if (arvalid && ar_rdy) begin
                r_busy <= 1'b1;
                r_lst  <= arlen == 4'd0;
                r_left <= arlen;
                r_addr <= araddr;
                r_dat  <= read_word(araddr);
            end

            // address, then data beats, then response
            if (w_busy) begin
                if (wvalid && w_rdy) begin
                    merged = read_word(w_addr);
                    for (int b = 0; b < 4; b++) begin
                        if (wstrb[b]) begin
                            merged[8*b +: 8] = wdata_bus[8*b +: 8];
                        end
                    end
                    mem[w_addr] = merged;
                    w_addr <= w_addr + 4;
                    if (wlast) begin
                        w_busy <= 1'b0;
                        b_vld  <= 1'b1;
                    end
                end
            end else if (b_vld) begin
                if (bready) begin
                    b_vld <= 1'b0;
                end
            end else if (awvalid && aw_rdy) begin
                w_busy <= 1'b1;
                w_addr <= {awaddr[31:2], 2'b00};
            end
        end
    end

endmodule

/* sim/dcache_tb.sv */
`timescale 1ns/1ps

module dcache_tb
    import dcache_pkg::*;
    import dcache_axi_pkg::*;
();

    localparam int   CLK_PERIOD     = 20;
    localparam int   SETTLE         = 5;   // inputs and flops quiet from here to the edge
    localparam int   RESET_CYCLES   = 10;
    localparam int   ROWS           = 23;
    localparam int   TIMEOUT_CYCLES = ROWS * 200 + RESET_CYCLES;
    localparam int   BURST_LEN_CODE = 7;   // 8 words per line
    localparam int   SIZE_CODE      = 2;   // 4-byte beats
    localparam int   SEED           = 32'he23379a4;
    localparam logic OP_LD          = 1'b0;
    localparam logic OP_ST          = 1'b1;

    logic      clk;
    logic      rst;
    logic      req;
    addr_t     addr;
    strb_t     wen;
    word_t     wdata;
    word_t     rdata;
    logic      stall;
    addr_t     araddr;
    axi_len_t  arlen;
    axi_size_t arsize;
    logic      arvalid;
    logic      arready;
    word_t     rdata_bus;
    logic      rlast;
    logic      rvalid;
    logic      rready;
    addr_t     awaddr;
    axi_len_t  awlen;
    axi_size_t awsize;
    logic      awvalid;
    logic      awready;
    word_t     wdata_bus;
    strb_t     wstrb;
    logic      wlast;
    logic      wvalid;
    logic      wready;
    logic      bvalid;
    logic      bready;

    // operation table with the ar and aw handshakes expected during each row
    logic  row_st    [ROWS];
    addr_t row_addr  [ROWS];
    strb_t row_strb  [ROWS];
    word_t row_wdata [ROWS];
    word_t row_exp   [ROWS];
    int    row_ar    [ROWS];
    int    row_aw    [ROWS];
    int    n_rows   = 0;
    int    ar_count = 0;
    int    aw_count = 0;
    int    cycles   = 0;

    dcache_top i_dcache_top (
        .clk       (clk),
        .rst       (rst),
        .req       (req),
        .addr      (addr),
        .wen       (wen),
        .wdata     (wdata),
        .rdata     (rdata),
        .stall     (stall),
        .araddr    (araddr),
        .arlen     (arlen),
        .arsize    (arsize),
        .arvalid   (arvalid),
        .arready   (arready),
        .rdata_bus (rdata_bus),
        .rlast     (rlast),
        .rvalid    (rvalid),
        .rready    (rready),
        .awaddr    (awaddr),
        .awlen     (awlen),
        .awsize    (awsize),
        .awvalid   (awvalid),
        .awready   (awready),
        .wdata_bus (wdata_bus),
        .wstrb     (wstrb),
        .wlast     (wlast),
        .wvalid    (wvalid),
        .wready    (wready),
        .bvalid    (bvalid),
        .bready    (bready)
    );

    axi_mem_model #(
        .SEED (SEED)
    ) i_mem (
        .clk       (clk),
        .rst       (rst),
        .araddr    (araddr),
        .arlen     (arlen),
        .arvalid   (arvalid),
        .arready   (arready),
        .rdata_bus (rdata_bus),
        .rlast     (rlast),
        .rvalid    (rvalid),
        .rready    (rready),
        .awaddr    (awaddr),
        .awvalid   (awvalid),
        .awready   (awready),
        .wdata_bus (wdata_bus),
        .wstrb     (wstrb),
        .wlast     (wlast),
        .wvalid    (wvalid),
        .wready    (wready),
        .bvalid    (bvalid),
        .bready    (bready)
    );

    initial begin
        clk = 1'b0;
        forever #(CLK_PERIOD / 2) clk = ~clk;
    end

    // memory word before any store
    function automatic word_t init_word(addr_t a);
        return {a[31:2], 2'b00} ^ 32'hc0de0000;
    endfunction

    function automatic word_t merge_bytes(word_t old_word, word_t new_word, strb_t strb);
        word_t w;
        w = old_word;
        for (int b = 0; b < 4; b++) begin
            if (strb[b]) begin
                w[8*b +: 8] = new_word[8*b +: 8];
            end
        end
        return w;
    endfunction

    task automatic check(input string name, input logic [31:0] got, input logic [31:0] exp);
        if (got !== exp) begin
            $display("ERROR %s: got %h, expected %h", name, got, exp);
            $display("=== FAIL ===");
            $fatal(1, "stopped at the first mismatch");
        end
    endtask

    task automatic add_row(input logic st, input addr_t a, input strb_t s, input word_t d,
                           input word_t e, input int ar, input int aw);
        if (n_rows < ROWS) begin
            row_st[n_rows]    = st;
            row_addr[n_rows]  = a;
            row_strb[n_rows]  = s;
            row_wdata[n_rows] = d;
            row_exp[n_rows]   = e;
            row_ar[n_rows]    = ar;
            row_aw[n_rows]    = aw;
        end
        n_rows++;
    endtask

    // 128 sets of 32-byte lines and the tag starts at bit 12
    task automatic fill_table();
        // cold miss and then a hit in the same line
        add_row(OP_LD, 32'h0000_0044, 4'h0, '0, init_word(32'h44), 1, 0);
        add_row(OP_LD, 32'h0000_0058, 4'h0, '0, init_word(32'h58), 0, 0);
        // partial store on a hit
        add_row(OP_ST, 32'h0000_0048, 4'b0110, 32'h1122_3344, '0, 0, 0);
        add_row(OP_LD, 32'h0000_0048, 4'h0, '0,
                merge_bytes(init_word(32'h48), 32'h1122_3344, 4'b0110), 0, 0);
        // partial store on a miss is merged into the refill
        add_row(OP_ST, 32'h0000_0104, 4'b1001, 32'haabb_ccdd, '0, 1, 0);
        add_row(OP_LD, 32'h0000_0104, 4'h0, '0,
                merge_bytes(init_word(32'h104), 32'haabb_ccdd, 4'b1001), 0, 0);
        add_row(OP_LD, 32'h0000_0108, 4'h0, '0, init_word(32'h108), 0, 0);
        // five tags in set 0x10 and the fifth evicts the clean first one
        add_row(OP_LD, 32'h0000_1200, 4'h0, '0, init_word(32'h1200), 1, 0);
        add_row(OP_LD, 32'h0000_2204, 4'h0, '0, init_word(32'h2204), 1, 0);
        add_row(OP_LD, 32'h0000_3208, 4'h0, '0, init_word(32'h3208), 1, 0);
        add_row(OP_LD, 32'h0000_420c, 4'h0, '0, init_word(32'h420c), 1, 0);
        add_row(OP_LD, 32'h0000_5210, 4'h0, '0, init_word(32'h5210), 1, 0);
        add_row(OP_LD, 32'h0000_1214, 4'h0, '0, init_word(32'h1214), 1, 0);
        add_row(OP_LD, 32'h0000_5210, 4'h0, '0, init_word(32'h5210), 0, 0);  // still way 0
        // a dirty line in set 0x20 goes out once and then comes back
        add_row(OP_ST, 32'h0000_1404, 4'hf, 32'hdead_beef, '0, 1, 0);
        add_row(OP_LD, 32'h0000_2400, 4'h0, '0, init_word(32'h2400), 1, 0);
        add_row(OP_LD, 32'h0000_3400, 4'h0, '0, init_word(32'h3400), 1, 0);
        add_row(OP_LD, 32'h0000_4400, 4'h0, '0, init_word(32'h4400), 1, 0);
        add_row(OP_LD, 32'h0000_5400, 4'h0, '0, init_word(32'h5400), 1, 1);
        add_row(OP_LD, 32'h0000_1404, 4'h0, '0, 32'hdead_beef, 1, 0);
        add_row(OP_LD, 32'h0000_1400, 4'h0, '0, init_word(32'h1400), 0, 0);
        // second store on top of the first
        add_row(OP_ST, 32'h0000_0048, 4'b1000, 32'h9900_0000, '0, 0, 0);
        add_row(OP_LD, 32'h0000_0048, 4'h0, '0,
                merge_bytes(merge_bytes(init_word(32'h48), 32'h1122_3344, 4'b0110),
                            32'h9900_0000, 4'b1000), 0, 0);
    endtask

    // handshakes counted at the edge where they happen
    always @(posedge clk) begin
        if (!rst && arvalid && arready) begin
            ar_count++;
            check("arlen", 32'(arlen), BURST_LEN_CODE);
            check("arsize", 32'(arsize), SIZE_CODE);
            check("araddr[4:0]", 32'(araddr[4:0]), 32'd0);
        end
        if (!rst && awvalid && awready) begin
            aw_count++;
            check("awlen", 32'(awlen), BURST_LEN_CODE);
            check("awsize", 32'(awsize), SIZE_CODE);
            check("awaddr[4:0]", 32'(awaddr[4:0]), 32'd0);
        end
    end

    always @(posedge clk) begin
        cycles++;
        if (cycles > TIMEOUT_CYCLES) begin
            $display("timeout: the cache did not finish within %0d cycles", TIMEOUT_CYCLES);
            $display("=== FAIL ===");
            $fatal(1, "simulation timed out");
        end
    end

    initial begin
        word_t got;
        int    ar_before;
        int    aw_before;
        int    waits;
        rst   = 1'b1;
        req   = 1'b0;
        addr  = '0;
        wen   = '0;
        wdata = '0;
        fill_table();
        if (n_rows != ROWS) begin
            $display("the table holds %0d rows instead of %0d", n_rows, ROWS);
            $display("=== FAIL ===");
            $fatal(1, "wrong table size");
        end
        repeat (RESET_CYCLES) @(posedge clk);
        @(negedge clk);
        rst = 1'b0;
        #SETTLE;
        check("stall", 32'(stall), 32'd0);  // idle after reset
        check("arvalid", 32'(arvalid), 32'd0);
        check("awvalid", 32'(awvalid), 32'd0);
        check("wvalid", 32'(wvalid), 32'd0);
        check("rready", 32'(rready), 32'd0);
        check("bready", 32'(bready), 32'd0);

        for (int i = 0; i < ROWS; i++) begin
            @(negedge clk);
            ar_before = ar_count;
            aw_before = aw_count;
            req   = 1'b1;
            addr  = row_addr[i];
            wen   = row_strb[i];
            wdata = row_wdata[i];
            #SETTLE;
            waits = 0;
            while (stall) begin
                @(negedge clk);
                #SETTLE;
                waits++;
            end
            got = rdata;  // completes at the coming edge
            @(negedge clk);
            req = 1'b0;
            wen = '0;
            if (row_st[i] == OP_LD) begin
                check($sformatf("rdata (row %0d)", i), got, row_exp[i]);
            end
            check($sformatf("ar handshakes (row %0d)", i), ar_count - ar_before, row_ar[i]);
            check($sformatf("aw handshakes (row %0d)", i), aw_count - aw_before, row_aw[i]);
            if (row_ar[i] == 0 && row_aw[i] == 0) begin
                // a hit completes one cycle after req is first seen
                check($sformatf("stall cycles (row %0d)", i), waits, 1);
            end
        end

        $display("=== PASS ===");
        $finish;
    end

endmodule

/* filelist.f */
src/dcache_pkg.sv
src/dcache_axi_pkg.sv
src/dcache_sram.sv
src/dcache_way.sv
src/dcache_plru.sv
src/dcache_ctrl.sv
src/dcache_top.sv
sim/axi_mem_model.sv
sim/dcache_tb.sv

/* run.sh */
#!/usr/bin/env bash
# build the data cache testbench with Verilator and run it

cd "$(dirname "$0")" || exit 1

verilator --binary --timing -j 0 --top-module dcache_tb -f filelist.f -o dcache_sim
if [ $? -ne 0 ]; then
    echo "verilator build failed"
    exit 1
fi

output=$(./obj_dir/dcache_sim 2>&1)
status=$?
echo "$output"
if [ $status -ne 0 ]; then
    echo "simulation exited with status $status"
fi

if grep -qx "=== PASS ===" <<< "$output"; then
    exit 0
fi
exit 1
